//--- logic/fetchPkg.sv
package fetchPkg;

  localparam int AddrWidth   = 32;  // Byte address width of the whole front end
  localparam int InstBytes   = 4;  // Every instruction has the same size
  localparam int BundleSlots = 4;  // Instructions looked up together each cycle
  localparam int BundleBytes = BundleSlots * InstBytes;  // Stride between bundles, 16 bytes
  localparam int OffsetBits  = $clog2(BundleBytes);  // Byte offset bits inside one bundle
  localparam int SlotBits    = $clog2(BundleSlots);  // Bits needed to name a slot
  localparam int InstLsb     = $clog2(InstBytes);  // Lowest address bit that selects a slot

  typedef logic [AddrWidth-1:0] pcT;  // Byte address of an instruction or a bundle
  typedef logic [SlotBits-1:0]  slotT;  // Position of an instruction inside its bundle

  // Clears the byte offset so that the address names a whole bundle
  function automatic pcT bundleAlign(pcT addr);
    return {addr[AddrWidth-1:OffsetBits], {OffsetBits{1'b0}}};
  endfunction

  // Slot that an instruction address falls into, used to pick a bank
  function automatic slotT slotOf(pcT addr);
    return addr[InstLsb+:SlotBits];
  endfunction

endpackage

//--- logic/predictPkg.sv
package predictPkg;

  typedef logic [1:0] brKindT;  // Kind of control transfer held by a buffer entry

  localparam brKindT KindReturn = 2'b00;  // Target comes from the return address stack
  localparam brKindT KindCall   = 2'b01;  // Direct or indirect call, pushes a return address
  localparam brKindT KindJump   = 2'b10;  // Unconditional jump, always taken on a hit
  localparam brKindT KindCond   = 2'b11;  // Conditional branch, direction from the counters

  typedef logic [1:0] ctrT;  // Two-bit saturating direction counter

  localparam ctrT CtrMin      = 2'b00;  // Strongly not taken
  localparam ctrT CtrInit     = 2'b01;  // Weakly not taken, the value after reset
  localparam ctrT CtrTakenMin = 2'b10;  // Lowest value that predicts taken
  localparam ctrT CtrMax      = 2'b11;  // Strongly taken

endpackage

//--- logic/updateCapture.sv
`timescale 1ns/1ps

module updateCapture (
  input  logic               clk,
  input  logic               reset,
  input  logic               recoverFlag_i,
  input  fetchPkg::pcT       recoverPc_i,
  input  logic               exceptionFlag_i,
  input  fetchPkg::pcT       exceptionPc_i,
  input  logic               decodeRedirect_i,
  input  fetchPkg::pcT       decodeTarget_i,
  input  logic               updateEn_i,
  input  fetchPkg::pcT       updatePc_i,
  input  fetchPkg::pcT       updateTarget_i,
  input  predictPkg::brKindT updateKind_i,
  input  logic               updateTaken_i,
  output logic               redirValid_o,
  output fetchPkg::pcT       redirPc_o,
  output logic               btbWrEn_o,
  output fetchPkg::pcT       btbWrPc_o,
  output fetchPkg::pcT       btbWrTarget_o,
  output predictPkg::brKindT btbWrKind_o,
  output logic               ctrWrEn_o,
  output fetchPkg::pcT       ctrWrPc_o,
  output logic               ctrWrTaken_o
);
  import predictPkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      redirValid_o <= 1'b0;
      btbWrEn_o    <= 1'b0;
      ctrWrEn_o    <= 1'b0;
    end else begin
      redirValid_o <= recoverFlag_i | exceptionFlag_i | decodeRedirect_i;  // Any source redirects
      btbWrEn_o    <= updateEn_i && (updateKind_i != KindCond || updateTaken_i);  // Skip not-taken
      ctrWrEn_o    <= updateEn_i && (updateKind_i == KindCond);  // Only conditionals train
    end
  end

  // Recovery from commit beats an exception, which beats a decode redirect
  always_ff @(posedge clk) begin
    if (recoverFlag_i) redirPc_o <= recoverPc_i;
    else if (exceptionFlag_i) redirPc_o <= exceptionPc_i;
    else redirPc_o <= decodeTarget_i;
    btbWrPc_o     <= updatePc_i;
    btbWrTarget_o <= updateTarget_i;
    btbWrKind_o   <= updateKind_i;
    ctrWrPc_o     <= updatePc_i;
    ctrWrTaken_o  <= updateTaken_i;
  end

  // A write to both tables at once only ever comes from a conditional branch
  assert property (@(posedge clk) disable iff (reset)
    btbWrEn_o && ctrWrEn_o |-> btbWrKind_o == KindCond);

endmodule

//--- logic/branchTargetBuffer.sv
`timescale 1ns/1ps

module branchTargetBuffer #(
  parameter int BtbEntries = 16
) (
  input  logic               clk,
  input  logic               reset,
  input  fetchPkg::pcT       lookupPc_i,
  input  logic               wrEn_i,
  input  fetchPkg::pcT       wrPc_i,
  input  fetchPkg::pcT       wrTarget_i,
  input  predictPkg::brKindT wrKind_i,
  output logic               hit_o    [fetchPkg::BundleSlots],
  output predictPkg::brKindT kind_o   [fetchPkg::BundleSlots],
  output fetchPkg::pcT       target_o [fetchPkg::BundleSlots]
);
  import fetchPkg::*;
  import predictPkg::*;

  localparam int IdxBits = $clog2(BtbEntries);  // Bundle index bits above the offset
  localparam int TagBits = AddrWidth - OffsetBits - IdxBits;  // Rest of the bundle address

  typedef logic [IdxBits-1:0] idxT;
  typedef logic [TagBits-1:0] tagT;

  logic   validQ  [BundleSlots][BtbEntries];  // Cleared by reset so every entry starts empty
  tagT    tagQ    [BundleSlots][BtbEntries];
  brKindT kindQ   [BundleSlots][BtbEntries];
  pcT     targetQ [BundleSlots][BtbEntries];

  idxT  lookupIdx;
  tagT  lookupTag;
  idxT  wrIdx;
  tagT  wrTag;
  slotT wrSlot;

  assign lookupIdx = lookupPc_i[OffsetBits+:IdxBits];  // Same row read in every bank
  assign lookupTag = lookupPc_i[AddrWidth-1-:TagBits];
  assign wrIdx     = wrPc_i[OffsetBits+:IdxBits];
  assign wrTag     = wrPc_i[AddrWidth-1-:TagBits];
  assign wrSlot    = slotOf(wrPc_i);  // Slot of the branch picks the bank it lands in

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < BundleSlots; s++) begin
        for (int e = 0; e < BtbEntries; e++) begin
          validQ[s][e] <= 1'b0;
        end
      end
    end else if (wrEn_i) begin
      validQ[wrSlot][wrIdx] <= 1'b1;  // A later branch with the same index replaces the entry
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      tagQ[wrSlot][wrIdx]    <= wrTag;
      kindQ[wrSlot][wrIdx]   <= wrKind_i;
      targetQ[wrSlot][wrIdx] <= wrTarget_i;
    end
  end

  // All four banks answer in the same cycle as the lookup address
  always_comb begin
    for (int s = 0; s < BundleSlots; s++) begin
      hit_o[s]    = validQ[s][lookupIdx] && (tagQ[s][lookupIdx] == lookupTag);
      kind_o[s]   = kindQ[s][lookupIdx];
      target_o[s] = targetQ[s][lookupIdx];
    end
  end

endmodule

//--- logic/directionPredictor.sv
`timescale 1ns/1ps

module directionPredictor #(
  parameter int BtbEntries = 16
) (
  input  logic         clk,
  input  logic         reset,
  input  fetchPkg::pcT lookupPc_i,
  input  logic         wrEn_i,
  input  fetchPkg::pcT wrPc_i,
  input  logic         wrTaken_i,
  output logic         taken_o [fetchPkg::BundleSlots]
);
  import fetchPkg::*;
  import predictPkg::*;

  localparam int IdxBits = $clog2(BtbEntries);  // Indexed exactly like the target buffer

  typedef logic [IdxBits-1:0] idxT;

  ctrT  ctrQ [BundleSlots][BtbEntries];
  idxT  lookupIdx;
  idxT  wrIdx;
  slotT wrSlot;
  ctrT  wrOld;

  assign lookupIdx = lookupPc_i[OffsetBits+:IdxBits];
  assign wrIdx     = wrPc_i[OffsetBits+:IdxBits];
  assign wrSlot    = slotOf(wrPc_i);
  assign wrOld     = ctrQ[wrSlot][wrIdx];  // Counter being trained this cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < BundleSlots; s++) begin
        for (int e = 0; e < BtbEntries; e++) begin
          ctrQ[s][e] <= CtrInit;
        end
      end
    end else if (wrEn_i) begin
      if (wrTaken_i && wrOld != CtrMax) ctrQ[wrSlot][wrIdx] <= wrOld + 2'd1;  // Saturates at top
      else if (!wrTaken_i && wrOld != CtrMin) ctrQ[wrSlot][wrIdx] <= wrOld - 2'd1;
    end
  end

  always_comb begin
    for (int s = 0; s < BundleSlots; s++) begin
      taken_o[s] = (ctrQ[s][lookupIdx] >= CtrTakenMin);  // Upper half of the range is taken
    end
  end

endmodule

//--- logic/returnAddrStack.sv
`timescale 1ns/1ps

module returnAddrStack #(
  parameter int RasDepth = 8
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         push_i,
  input  fetchPkg::pcT pushAddr_i,
  input  logic         pop_i,
  output fetchPkg::pcT top_o
);
  import fetchPkg::*;

  localparam int PtrBits   = $clog2(RasDepth);
  localparam int CountBits = $clog2(RasDepth + 1);  // Must be able to hold a full stack

  typedef logic [PtrBits-1:0]   ptrT;
  typedef logic [CountBits-1:0] countT;

  pcT    stackQ [RasDepth];
  ptrT   topPtrQ;  // Points at the newest entry
  countT countQ;  // Live entries, stops at RasDepth once the oldest gets overwritten
  ptrT   nextPtr;
  ptrT   prevPtr;

  assign nextPtr = (topPtrQ == ptrT'(RasDepth - 1)) ? '0 : topPtrQ + 1'b1;  // Wraps around
  assign prevPtr = (topPtrQ == '0) ? ptrT'(RasDepth - 1) : topPtrQ - 1'b1;
  assign top_o   = stackQ[topPtrQ];

  always_ff @(posedge clk) begin
    if (reset) begin
      topPtrQ <= '0;
      countQ  <= '0;
    end else if (push_i) begin
      topPtrQ <= nextPtr;
      if (countQ != countT'(RasDepth)) countQ <= countQ + 1'b1;
    end else if (pop_i && countQ != '0) begin
      topPtrQ <= prevPtr;  // An empty stack keeps its pointer and so its last top
      countQ  <= countQ - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) stackQ[nextPtr] <= pushAddr_i;
  end

  // Only one slot of a bundle wins, so a call and a return never act together
  assert property (@(posedge clk) disable iff (reset) !(push_i && pop_i));

endmodule

//--- logic/nextPcSelect.sv
`timescale 1ns/1ps

module nextPcSelect #(
  parameter fetchPkg::pcT ResetPc = '0
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               fetchGo_i,
  input  logic               redirValid_i,
  input  fetchPkg::pcT       redirPc_i,
  input  logic               hit_i    [fetchPkg::BundleSlots],
  input  predictPkg::brKindT kind_i   [fetchPkg::BundleSlots],
  input  fetchPkg::pcT       target_i [fetchPkg::BundleSlots],
  input  logic               taken_i  [fetchPkg::BundleSlots],
  input  fetchPkg::pcT       rasTop_i,
  output fetchPkg::pcT       fetchPc_o,
  output fetchPkg::pcT       nextPc_o,
  output logic               predHit_o,
  output fetchPkg::slotT     predSlot_o,
  output logic               push_o,
  output fetchPkg::pcT       pushAddr_o,
  output logic               pop_o
);
  import fetchPkg::*;
  import predictPkg::*;

  pcT     fetchPcQ;
  logic   slotTaken [BundleSlots];
  logic   winHit;
  slotT   winSlot;
  brKindT winKind;
  pcT     winTarget;
  pcT     rawNext;

  // A hit redirects unless it is a conditional branch whose counter says not taken
  always_comb begin
    for (int s = 0; s < BundleSlots; s++) begin
      slotTaken[s] = hit_i[s] && (kind_i[s] != KindCond || taken_i[s]);
    end
  end

  // Walking down from the last slot leaves the lowest taken slot as the winner
  always_comb begin
    winHit  = 1'b0;
    winSlot = '0;
    for (int s = BundleSlots - 1; s >= 0; s--) begin
      if (slotTaken[s]) begin
        winHit  = 1'b1;
        winSlot = slotT'(s);
      end
    end
  end

  assign winKind   = kind_i[winSlot];
  assign winTarget = target_i[winSlot];

  always_comb begin
    if (winHit && winKind == KindReturn) rawNext = rasTop_i;  // Return goes to the stack top
    else if (winHit) rawNext = winTarget;
    else rawNext = fetchPcQ + pcT'(BundleBytes);  // Sequential fall-through
  end

  assign nextPc_o = bundleAlign(rawNext);  // Fetch works on whole bundles only

  // Return address is the instruction right after the call
  assign push_o     = fetchGo_i && winHit && (winKind == KindCall);
  assign pushAddr_o = fetchPcQ + pcT'((int'(winSlot) + 1) * InstBytes);
  assign pop_o      = fetchGo_i && winHit && (winKind == KindReturn);

  assign fetchPc_o  = fetchPcQ;
  assign predHit_o  = winHit;
  assign predSlot_o = winSlot;

  always_ff @(posedge clk) begin
    if (reset) fetchPcQ <= ResetPc;
    else if (redirValid_i) fetchPcQ <= bundleAlign(redirPc_i);  // Loads even without credits
    else if (fetchGo_i) fetchPcQ <= nextPc_o;  // Holds under back-pressure
  end

endmodule

//--- logic/fetchPacketOut.sv
`timescale 1ns/1ps

module fetchPacketOut #(
  parameter int NumCredits = 4
) (
  input  logic           clk,
  input  logic           reset,
  input  fetchPkg::pcT   fetchPc_i,
  input  fetchPkg::pcT   nextPc_i,
  input  logic           predHit_i,
  input  fetchPkg::slotT predSlot_i,
  input  logic           creditReturn_i,
  output logic           fetchGo_o,
  output logic           packetValid_o,
  output fetchPkg::pcT   packetPc_o,
  output fetchPkg::pcT   packetNextPc_o,
  output logic           packetHit_o,
  output fetchPkg::slotT packetSlot_o
);

  localparam int CreditBits = $clog2(NumCredits + 1);  // Wide enough for a full count

  typedef logic [CreditBits-1:0] creditT;

  creditT creditQ;  // Free slots left in the decode buffer

  assign fetchGo_o = (creditQ != '0);  // One free slot is enough for one packet

  // Spend and return may land together and then cancel out
  always_ff @(posedge clk) begin
    if (reset) begin
      creditQ       <= creditT'(NumCredits);
      packetValid_o <= 1'b0;
    end else begin
      creditQ       <= creditQ - creditT'(fetchGo_o) + creditT'(creditReturn_i);
      packetValid_o <= fetchGo_o;  // A single-cycle pulse per issued packet
    end
  end

  always_ff @(posedge clk) begin
    if (fetchGo_o) begin
      packetPc_o     <= fetchPc_i;
      packetNextPc_o <= nextPc_i;
      packetHit_o    <= predHit_i;
      packetSlot_o   <= predSlot_i;
    end
  end

  // Decode can only hand back credits that were spent on packets still in flight
  assert property (@(posedge clk) disable iff (reset) creditQ <= creditT'(NumCredits));
  assert property (@(posedge clk) disable iff (reset)
    creditReturn_i |-> creditQ != creditT'(NumCredits));

endmodule

//--- logic/fetchFrontEnd.sv
`timescale 1ns/1ps

module fetchFrontEnd #(
  parameter int           BtbEntries = 16,
  parameter int           RasDepth   = 8,
  parameter int           NumCredits = 4,
  parameter fetchPkg::pcT ResetPc    = '0
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               recoverFlag_i,
  input  fetchPkg::pcT       recoverPc_i,
  input  logic               exceptionFlag_i,
  input  fetchPkg::pcT       exceptionPc_i,
  input  logic               decodeRedirect_i,
  input  fetchPkg::pcT       decodeTarget_i,
  input  logic               updateEn_i,
  input  fetchPkg::pcT       updatePc_i,
  input  fetchPkg::pcT       updateTarget_i,
  input  predictPkg::brKindT updateKind_i,
  input  logic               updateTaken_i,
  input  logic               creditReturn_i,
  output logic               packetValid_o,
  output fetchPkg::pcT       packetPc_o,
  output fetchPkg::pcT       packetNextPc_o,
  output logic               packetHit_o,
  output fetchPkg::slotT     packetSlot_o
);
  import fetchPkg::*;
  import predictPkg::*;

  logic   redirValid;  // Registered redirect, already resolved by priority
  pcT     redirPc;
  logic   btbWrEn;
  pcT     btbWrPc;
  pcT     btbWrTarget;
  brKindT btbWrKind;
  logic   ctrWrEn;
  pcT     ctrWrPc;
  logic   ctrWrTaken;
  pcT     fetchPc;  // Current bundle address, shared by every lookup
  pcT     nextPc;
  logic   predHit;
  slotT   predSlot;
  logic   btbHit    [BundleSlots];
  brKindT btbKind   [BundleSlots];
  pcT     btbTarget [BundleSlots];
  logic   ctrTaken  [BundleSlots];
  logic   rasPush;
  pcT     rasPushAddr;
  logic   rasPop;
  pcT     rasTop;
  logic   fetchGo;  // Low while decode has no free slot

  updateCapture i_updateCapture (
    .clk(clk), .reset(reset),
    .recoverFlag_i(recoverFlag_i), .recoverPc_i(recoverPc_i),
    .exceptionFlag_i(exceptionFlag_i), .exceptionPc_i(exceptionPc_i),
    .decodeRedirect_i(decodeRedirect_i), .decodeTarget_i(decodeTarget_i),
    .updateEn_i(updateEn_i), .updatePc_i(updatePc_i), .updateTarget_i(updateTarget_i),
    .updateKind_i(updateKind_i), .updateTaken_i(updateTaken_i),
    .redirValid_o(redirValid), .redirPc_o(redirPc),
    .btbWrEn_o(btbWrEn), .btbWrPc_o(btbWrPc), .btbWrTarget_o(btbWrTarget),
    .btbWrKind_o(btbWrKind),
    .ctrWrEn_o(ctrWrEn), .ctrWrPc_o(ctrWrPc), .ctrWrTaken_o(ctrWrTaken)
  );

  branchTargetBuffer #(.BtbEntries(BtbEntries)) i_branchTargetBuffer (
    .clk(clk), .reset(reset), .lookupPc_i(fetchPc),
    .wrEn_i(btbWrEn), .wrPc_i(btbWrPc), .wrTarget_i(btbWrTarget), .wrKind_i(btbWrKind),
    .hit_o(btbHit), .kind_o(btbKind), .target_o(btbTarget)
  );

  directionPredictor #(.BtbEntries(BtbEntries)) i_directionPredictor (
    .clk(clk), .reset(reset), .lookupPc_i(fetchPc),
    .wrEn_i(ctrWrEn), .wrPc_i(ctrWrPc), .wrTaken_i(ctrWrTaken), .taken_o(ctrTaken)
  );

  returnAddrStack #(.RasDepth(RasDepth)) i_returnAddrStack (
    .clk(clk), .reset(reset), .push_i(rasPush), .pushAddr_i(rasPushAddr),
    .pop_i(rasPop), .top_o(rasTop)
  );

  nextPcSelect #(.ResetPc(ResetPc)) i_nextPcSelect (
    .clk(clk), .reset(reset), .fetchGo_i(fetchGo),
    .redirValid_i(redirValid), .redirPc_i(redirPc),
    .hit_i(btbHit), .kind_i(btbKind), .target_i(btbTarget), .taken_i(ctrTaken),
    .rasTop_i(rasTop), .fetchPc_o(fetchPc), .nextPc_o(nextPc),
    .predHit_o(predHit), .predSlot_o(predSlot),
    .push_o(rasPush), .pushAddr_o(rasPushAddr), .pop_o(rasPop)
  );

  fetchPacketOut #(.NumCredits(NumCredits)) i_fetchPacketOut (
    .clk(clk), .reset(reset), .fetchPc_i(fetchPc), .nextPc_i(nextPc),
    .predHit_i(predHit), .predSlot_i(predSlot), .creditReturn_i(creditReturn_i),
    .fetchGo_o(fetchGo), .packetValid_o(packetValid_o), .packetPc_o(packetPc_o),
    .packetNextPc_o(packetNextPc_o), .packetHit_o(packetHit_o), .packetSlot_o(packetSlot_o)
  );

endmodule

//--- test/fetchRefModel.svh
`ifndef FETCH_REF_MODEL_SVH
`define FETCH_REF_MODEL_SVH

localparam int RefEntries = 16;  // Rows per bank, same as the DUT default
localparam int RefDepth   = 8;  // Return stack depth

logic   refValid  [4][RefEntries];
logic   [23:0] refTag [4][RefEntries];  // Address bits above the row index
brKindT refKind   [4][RefEntries];
pcT     refTarget [4][RefEntries];
ctrT    refCtr    [4][RefEntries];
pcT     refStack  [RefDepth];
int     refPtr = 0;  // Newest stack entry
int     refCount = 0;

// Empties the tables, counters start weakly not taken
function automatic void modelReset();
  for (int s = 0; s < 4; s++) begin
    for (int e = 0; e < RefEntries; e++) begin
      refValid[s][e] = 1'b0;
      refCtr[s][e]   = 2'b01;
    end
  end
endfunction

// Buffer write unless a not-taken conditional, counter training only for conditionals
function automatic void modelUpdate(input pcT pc, input pcT target, input brKindT kind,
                                    input logic taken);
  int s;
  int e;
  s = int'(pc[3:2]);
  e = int'(pc[7:4]);
  if (kind != KindCond || taken) begin
    refValid[s][e]  = 1'b1;
    refTag[s][e]    = pc[31:8];
    refKind[s][e]   = kind;
    refTarget[s][e] = target;
  end
  if (kind == KindCond) begin
    if (taken && refCtr[s][e] != 2'b11) refCtr[s][e] = refCtr[s][e] + 2'b01;
    else if (!taken && refCtr[s][e] != 2'b00) refCtr[s][e] = refCtr[s][e] - 2'b01;
  end
endfunction

// Expected next bundle address of a packet fetched at pc
function automatic pcT predictNext(input pcT pc, output logic hit, output slotT slot,
                                   output brKindT kind);
  int e;
  pcT next;
  e    = int'(pc[7:4]);
  hit  = 1'b0;
  slot = 2'd0;
  kind = KindJump;
  next = pc + 32'd16;  // Sequential unless some slot is taken
  for (int s = 0; s < 4; s++) begin
    if (!hit && refValid[s][e] && refTag[s][e] == pc[31:8] &&
        (refKind[s][e] != KindCond || refCtr[s][e] >= 2'b10)) begin
      hit  = 1'b1;
      slot = slotT'(s);
      kind = refKind[s][e];
      next = (kind == KindReturn) ? refStack[refPtr] : refTarget[s][e];
    end
  end
  return {next[31:4], 4'h0};
endfunction

// Calls push the address after the call, returns pop unless the stack is empty
function automatic void modelAdvance(input pcT pc, input logic hit, input slotT slot,
                                     input brKindT kind);
  if (hit && kind == KindCall) begin
    refPtr = (refPtr + 1) % RefDepth;
    refStack[refPtr] = pc + 32'd4 * 32'(slot) + 32'd4;
    if (refCount < RefDepth) refCount++;
  end else if (hit && kind == KindReturn && refCount > 0) begin
    refPtr = (refPtr + RefDepth - 1) % RefDepth;
    refCount--;
  end
endfunction

`endif

//--- test/tbFetchFrontEnd.sv
`timescale 1ns/1ps

module tbFetchFrontEnd;
  import fetchPkg::*;
  import predictPkg::*;

  `include "fetchRefModel.svh"

  localparam int NumCredits    = 4;
  localparam int TimeoutCycles = 4000;  // About six times the length of all tests

  logic clk;
  logic reset;
  logic recoverFlag_i, exceptionFlag_i, decodeRedirect_i;
  pcT   recoverPc_i, exceptionPc_i, decodeTarget_i;
  logic updateEn_i, updateTaken_i, creditReturn_i;
  pcT   updatePc_i, updateTarget_i;
  brKindT updateKind_i;
  logic packetValid_o, packetHit_o;
  pcT   packetPc_o, packetNextPc_o;
  slotT packetSlot_o;

  int   seed = 37;
  int   cycles = 0;
  int   errors = 0;  // Written by the compare process only
  int   stimErrors = 0;  // Written by the stimulus only
  int   checks = 0;
  int   pktCount = 0;
  int   returned = 0;  // Credits handed back so far
  int   redirSeq = 0;
  int   seenSeq = 0;
  pcT   redirExp;
  pcT   expPc = '0;

  fetchFrontEnd i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, fetch stopped making progress", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Outputs are sampled at the falling edge where they are settled
  always @(negedge clk) begin
    logic   eHit;
    slotT   eSlot;
    brKindT eKind;
    pcT     eNext;
    if (redirSeq != seenSeq) begin
      expPc   = redirExp;  // Stream restarts at the redirect target
      seenSeq = redirSeq;
    end
    if (!reset && packetValid_o) begin
      eNext = predictNext(expPc, eHit, eSlot, eKind);
      checks++;
      if (packetPc_o !== expPc) begin
        $display("** Error: packetPc_o = %h, expected %h", packetPc_o, expPc);
        errors++;
      end
      if (packetNextPc_o !== eNext) begin
        $display("** Error: packetNextPc_o = %h, expected %h", packetNextPc_o, eNext);
        errors++;
      end
      if (packetHit_o !== eHit) begin
        $display("** Error: packetHit_o = %h, expected %h", packetHit_o, eHit);
        errors++;
      end
      if (eHit && packetSlot_o !== eSlot) begin
        $display("** Error: packetSlot_o = %h, expected %h", packetSlot_o, eSlot);
        errors++;
      end
      modelAdvance(expPc, eHit, eSlot, eKind);
      expPc = eNext;
      pktCount++;
    end
  end

  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Waits until every credit is spent, so nothing is left in flight
  task automatic waitDrain();
    while (pktCount != returned + NumCredits) tick(1);
    tick(3);
  endtask

  task automatic applyUpdate(input pcT pc, input pcT target, input brKindT kind,
                             input logic taken);
    updateEn_i     = 1'b1;
    updatePc_i     = pc;
    updateTarget_i = target;
    updateKind_i   = kind;
    updateTaken_i  = taken;
    modelUpdate(pc, target, kind, taken);  // Model tables change together with the DUT
    tick(1);
    updateEn_i = 1'b0;
    tick(3);
  endtask

  task automatic applyRedirect(input logic rec, input logic exc, input logic dec,
                               input pcT rPc, input pcT ePc, input pcT dPc, input pcT loadPc);
    recoverFlag_i    = rec;
    exceptionFlag_i  = exc;
    decodeRedirect_i = dec;
    recoverPc_i      = rPc;
    exceptionPc_i    = ePc;
    decodeTarget_i   = dPc;
    redirExp = {loadPc[31:4], 4'h0};
    redirSeq++;
    tick(1);
    recoverFlag_i    = 1'b0;
    exceptionFlag_i  = 1'b0;
    decodeRedirect_i = 1'b0;
    tick(3);
  endtask

  // One returned credit per cycle gives one packet each
  task automatic runPackets(input int n);
    for (int i = 0; i < n; i++) begin
      creditReturn_i = 1'b1;
      returned++;
      tick(1);
    end
    creditReturn_i = 1'b0;
    waitDrain();
  endtask

  task automatic jumpTo(input pcT pc);
    applyRedirect(1'b0, 1'b0, 1'b1, '0, '0, pc, pc);
  endtask

  initial begin
    int c0;
    pcT rPc;
    pcT rTgt;
    reset = 1'b1;
    {recoverFlag_i, exceptionFlag_i, decodeRedirect_i} = 3'b000;
    recoverPc_i = '0;
    exceptionPc_i = '0;
    decodeTarget_i = '0;
    updateEn_i = 1'b0;
    updatePc_i = '0;
    updateTarget_i = '0;
    updateKind_i = KindJump;
    updateTaken_i = 1'b0;
    creditReturn_i = 1'b0;
    modelReset();
    tick(8);
    reset = 1'b0;
    // Empty tables step by 16, and only the initial credits issue
    tick(20);
    if (pktCount != NumCredits) begin
      $display("Expected %0d packets without credit return, saw %0d", NumCredits, pktCount);
      stimErrors++;
    end
    runPackets(6);
    // Jump, then conditional trained taken and back to not taken
    applyUpdate(32'h1008, 32'h2000, KindJump, 1'b1);
    applyUpdate(32'h2004, 32'h3000, KindCond, 1'b1);
    applyUpdate(32'h2004, 32'h3000, KindCond, 1'b1);
    jumpTo(32'h1000);
    runPackets(4);
    applyUpdate(32'h2004, 32'h3000, KindCond, 1'b0);
    applyUpdate(32'h2004, 32'h3000, KindCond, 1'b0);
    jumpTo(32'h1000);
    runPackets(4);
    // Two jumps in one bundle, the lower slot wins
    applyUpdate(32'h300C, 32'h5000, KindJump, 1'b1);
    applyUpdate(32'h3004, 32'h6000, KindJump, 1'b1);
    jumpTo(32'h3000);
    runPackets(3);
    // Single call and return
    applyUpdate(32'h400C, 32'h7000, KindCall, 1'b1);
    applyUpdate(32'h7000, 32'h0, KindReturn, 1'b1);
    jumpTo(32'h4000);
    runPackets(5);
    // Nested calls to the full stack depth, each unwound by a return
    for (int k = 0; k < RefDepth; k++) begin
      applyUpdate(32'h8000 + 32'(k) * 32'h100 + 32'hC, 32'h8000 + 32'(k + 1) * 32'h100,
                  KindCall, 1'b1);
      applyUpdate(32'h8000 + 32'(k) * 32'h100 + 32'h10, 32'h0, KindReturn, 1'b1);
    end
    applyUpdate(32'h8800, 32'h0, KindReturn, 1'b1);
    jumpTo(32'h8000);
    runPackets(20);
    // Redirect priority
    applyRedirect(1'b1, 1'b1, 1'b1, 32'hA000, 32'hB000, 32'hC000, 32'hA000);
    runPackets(2);
    applyRedirect(1'b0, 1'b1, 1'b0, 32'hA000, 32'hB004, 32'hC000, 32'hB004);
    runPackets(2);
    applyRedirect(1'b1, 1'b0, 1'b0, 32'hA008, 32'hB000, 32'hC000, 32'hA008);
    runPackets(2);
    jumpTo(32'hC00C);
    runPackets(2);
    // Held credits stop fetch, one returned credit gives one packet
    c0 = pktCount;
    tick(10);
    if (pktCount != c0) begin
      $display("Packets issued with no credits left");
      stimErrors++;
    end
    creditReturn_i = 1'b1;
    returned++;
    tick(1);
    creditReturn_i = 1'b0;
    tick(5);
    if (pktCount != c0 + 1) begin
      $display("One returned credit gave %0d packets", pktCount - c0);
      stimErrors++;
    end
    // Random branches and a random credit pattern
    for (int i = 0; i < 8; i++) begin
      rPc  = {16'h0001, 4'h0, 10'($random(seed)), 2'b00};
      rTgt = {16'h0001, 4'h0, 10'($random(seed)), 2'b00};
      applyUpdate(rPc, rTgt, ($random(seed) & 1) ? KindCond : KindJump, 1'($random(seed)));
    end
    jumpTo(32'h10000);
    for (int i = 0; i < 300; i++) begin
      creditReturn_i = (pktCount > returned) && 1'($random(seed));  // Only spent credits
      if (creditReturn_i) returned++;
      tick(1);
    end
    creditReturn_i = 1'b0;
    waitDrain();
    $display("Checks: %0d, packet errors: %0d, other errors: %0d", checks, errors, stimErrors);
    if (errors == 0 && stimErrors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+test
logic/fetchPkg.sv
logic/predictPkg.sv
logic/updateCapture.sv
logic/branchTargetBuffer.sv
logic/directionPredictor.sv
logic/returnAddrStack.sv
logic/nextPcSelect.sv
logic/fetchPacketOut.sv
logic/fetchFrontEnd.sv
test/tbFetchFrontEnd.sv

//--- Makefile
# Verilator build of the fetch front end testbench
VERILATOR ?= verilator
TOP       ?= tbFetchFrontEnd
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation FAILED
PASS_MSG  ?= Simulation PASSED
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
